// File: Makefile
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_top_tb -f cpu_top.f

run: build
	./obj_dir/Vcpu_top_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only -Wall --top-module cpu_top source/cpu_pkg.sv \
		source/program_counter.sv source/control_main.sv source/register_file.sv \
		source/operand_forward.sv source/alu.sv source/execute_pipe.sv source/cpu_top.sv

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

// File: cpu_top.f
source/cpu_pkg.sv
source/program_counter.sv
source/control_main.sv
source/register_file.sv
source/operand_forward.sv
source/alu.sv
source/execute_pipe.sv
source/cpu_top.sv
sim/cpu_top_tb.sv

// File: sim/cpu_top_tb.sv
`timescale 1ns/1ps

module cpu_top_tb;

	// Program shape and run limit
	localparam int prog_count = 20;
	localparam int prog_len = 40;
	localparam int cycle_limit = prog_count * (prog_len + 20) * 2;
	localparam logic [15:0] halt_word = 16'hF000;

	logic clk;
	logic rst_n;
	logic [cpu_pkg::pc_w-1:0] pc;
	cpu_pkg::instr_u instr;
	cpu_pkg::wb_t wb;
	logic halted;

	// Program image and the model's ordered writes
	logic [15:0] prog_mem [prog_len];
	logic [cpu_pkg::reg_aw-1:0] exp_addr [$];
	logic [cpu_pkg::data_w-1:0] exp_data [$];
	logic [cpu_pkg::pc_w-1:0] exp_halt_pc;
	int seen;
	int value_errors;
	int other_errors;
	int cycles;
	logic [31:0] rng;

	cpu_top UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.pc     (pc),
		.instr  (instr),
		.wb     (wb),
		.halted (halted)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Words past the program read as halt
	function automatic logic [15:0] fetch_word(input logic [cpu_pkg::pc_w-1:0] addr);
		if (addr >= prog_len) begin
			return halt_word;
		end
		return prog_mem[addr[5:0]];
	endfunction

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [15:0] sext12(input logic [11:0] v);
		return {{4{v[11]}}, v};
	endfunction

	// Reference ALU, func 7 is a signed compare
	function automatic logic [15:0] model_alu(input logic [2:0] func, input logic [15:0] a,
			input logic [15:0] b);
		case (func)
			3'd0: return a + b;
			3'd1: return a - b;
			3'd2: return a & b;
			3'd3: return a | b;
			3'd4: return a ^ b;
			3'd5: return a << b[3:0];
			3'd6: return a >> b[3:0];
			default: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// Random program, registers from R0 to R7, forward-only branches
	task automatic gen_program();
		cpu_pkg::instr_u w;
		int kind;
		int off;
		for (int i = 0; i < prog_len - 1; i++) begin
			w = '0;
			rng = xorshift(rng);
			kind = int'(rng % 100);
			rng = xorshift(rng);
			off = 1 + int'(rng[23:16] % 3);
			// Target never passes the final halt word
			if (i + off > prog_len - 1) begin
				off = prog_len - 1 - i;
			end
			if (kind < 25) begin
				w.i_form.opcode = cpu_pkg::op_ldi;
				w.i_form.r1 = {1'b0, rng[2:0]};
				w.i_form.imm8 = rng[15:8];
			end else if (kind < 40) begin
				w.i_form.opcode = cpu_pkg::op_addi;
				w.i_form.r1 = {1'b0, rng[2:0]};
				w.i_form.imm8 = rng[15:8];
			end else if (kind < 80) begin
				w.r_form.opcode = cpu_pkg::op_alu;
				w.r_form.r1 = {1'b0, rng[2:0]};
				w.r_form.r2 = {1'b0, rng[6:4]};
				w.r_form.func = rng[11:8];
			end else if (kind < 90) begin
				w.i_form.opcode = cpu_pkg::op_beqz;
				w.i_form.r1 = {1'b0, rng[2:0]};
				w.i_form.imm8 = 8'(off);
			end else if (kind < 95) begin
				w.j_form.opcode = cpu_pkg::op_jmp;
				w.j_form.off12 = 12'(off);
			end else begin
				// Unused opcodes 5 to 14
				w.r_form.opcode = cpu_pkg::opcode_e'(4'(5 + rng[7:0] % 10));
				w.r_form.r1 = {1'b0, rng[2:0]};
				w.r_form.r2 = {1'b0, rng[6:4]};
			end
			prog_mem[i] = w;
		end
		prog_mem[prog_len-1] = halt_word;
	endtask

	// Sequential ISA run, one instruction at a time
	task automatic run_model();
		logic [15:0] regs [16];
		cpu_pkg::instr_u w;
		logic [15:0] mpc;
		logic [15:0] val;
		logic wr;
		bit done;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		mpc = '0;
		done = 1'b0;
		while (!done) begin
			w = fetch_word(mpc);
			wr = 1'b0;
			val = '0;
			case (w.r_form.opcode)
				cpu_pkg::op_alu: begin
					wr = 1'b1;
					val = model_alu(w.r_form.func[2:0], regs[w.r_form.r1], regs[w.r_form.r2]);
				end
				cpu_pkg::op_addi: begin
					wr = 1'b1;
					val = regs[w.i_form.r1] + sext8(w.i_form.imm8);
				end
				cpu_pkg::op_ldi: begin
					wr = 1'b1;
					val = sext8(w.i_form.imm8);
				end
				default: begin
				end
			endcase
			// R0 stays zero and is never reported
			if (wr && w.r_form.r1 != 4'd0) begin
				regs[w.r_form.r1] = val;
				exp_addr.push_back(w.r_form.r1);
				exp_data.push_back(val);
			end
			if (w.i_form.opcode == cpu_pkg::op_beqz && regs[w.i_form.r1] == 16'd0) begin
				mpc = mpc + sext8(w.i_form.imm8);
			end else if (w.j_form.opcode == cpu_pkg::op_jmp) begin
				mpc = mpc + sext12(w.j_form.off12);
			end else if (w.r_form.opcode == cpu_pkg::op_halt) begin
				exp_halt_pc = mpc;
				done = 1'b1;
			end else begin
				mpc = mpc + 16'd1;
			end
		end
	endtask

	// Reset for 3 cycles, then check the idle state
	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		instr = fetch_word('0);
		repeat (3) @(negedge clk);
		check_value("pc", pc, 16'd0);
		check_value("halted", 16'(halted), 16'd0);
		check_value("wb.we", 16'(wb.we), 16'd0);
		instr = fetch_word(pc);
		rst_n = 1'b1;
	endtask

	// Compare one retired write with the next expected one
	task automatic check_write();
		if (wb.we) begin
			if (seen >= exp_addr.size()) begin
				$display("Unexpected write to R%0d at %0t after all %0d model writes", wb.addr,
					$time, exp_addr.size());
				other_errors++;
			end else begin
				check_value("wb.addr", 16'(wb.addr), 16'(exp_addr[seen]));
				check_value("wb.data", wb.data, exp_data[seen]);
			end
			seen++;
		end
	endtask

	task automatic run_program(input int index);
		logic [cpu_pkg::pc_w-1:0] frozen_pc;
		seen = 0;
		// Feed the word at pc each cycle until the core halts
		while (halted !== 1'b1) begin
			@(negedge clk);
			check_write();
			instr = fetch_word(pc);
		end
		check_value("pc", pc, exp_halt_pc);
		frozen_pc = pc;
		// Halted core keeps pc and writes nothing
		repeat (4) begin
			@(negedge clk);
			check_write();
			check_value("pc", pc, frozen_pc);
			check_value("halted", 16'(halted), 16'd1);
			instr = fetch_word(pc);
		end
		if (seen != exp_addr.size()) begin
			$display("Program %0d retired %0d writes but the model made %0d", index, seen,
				exp_addr.size());
			other_errors++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		instr = halt_word;
		rng = 32'd8;
		value_errors = 0;
		other_errors = 0;
		seen = 0;
		for (int p = 0; p < prog_count; p++) begin
			gen_program();
			run_model();
			apply_reset();
			run_program(p);
		end
		$display("Checks done: %0d value errors, %0d other errors in %0d programs", value_errors,
			other_errors, prog_count);
		if (value_errors + other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog on total cycles
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Checks done: %0d value errors, %0d other errors before the timeout",
			value_errors, other_errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_e            alu_op,
	input  logic [cpu_pkg::data_w-1:0]  a,
	input  logic [cpu_pkg::data_w-1:0]  b,
	output logic [cpu_pkg::data_w-1:0]  result
);

	// Shift amount from the low nibble of b
	logic [3:0] shamt;
	logic lt;

	assign shamt = b[3:0];

	// Two's complement compare
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (alu_op)
			cpu_pkg::alu_add: begin
				result = a + b;
			end
			cpu_pkg::alu_sub: begin
				result = a - b;
			end
			cpu_pkg::alu_and: begin
				result = a & b;
			end
			cpu_pkg::alu_or: begin
				result = a | b;
			end
			cpu_pkg::alu_xor: begin
				result = a ^ b;
			end
			cpu_pkg::alu_shl: begin
				result = a << shamt;
			end
			// Logical, zero fill
			cpu_pkg::alu_shr: begin
				result = a >> shamt;
			end
			// 1 or 0, no flags kept
			cpu_pkg::alu_slt: begin
				result = {{(cpu_pkg::data_w-1){1'b0}}, lt};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: source/control_main.sv
`timescale 1ns/1ps

module control_main (
	input  logic                        clk,
	input  logic                        rst_n,
	input  cpu_pkg::instr_u             instr,
	input  logic [cpu_pkg::data_w-1:0]  operand_a,
	input  logic [cpu_pkg::data_w-1:0]  operand_b,
	output logic [cpu_pkg::reg_aw-1:0]  r1,
	output logic [cpu_pkg::reg_aw-1:0]  r2,
	output cpu_pkg::exec_t              issue,
	output logic                        redirect,
	output logic [cpu_pkg::pc_w-1:0]    jump_offset,
	output logic                        hold,
	output logic                        halted
);

	// Run/drain/halt sequencer
	typedef enum logic [1:0] {st_run, st_drain, st_halted} state_e;

	state_e state;
	logic drain_cnt;
	logic run;
	logic halt_dec;
	logic [cpu_pkg::data_w-1:0] imm_se;
	logic [cpu_pkg::pc_w-1:0] off_se;

	assign run = (state == st_run);

	// Read ports straight from the register fields
	assign r1 = instr.r_form.r1;
	assign r2 = instr.r_form.r2;

	// Sign extended immediates
	assign imm_se = {{(cpu_pkg::data_w-8){instr.i_form.imm8[7]}}, instr.i_form.imm8};
	assign off_se = {{(cpu_pkg::pc_w-12){instr.j_form.off12[11]}}, instr.j_form.off12};

	always_comb begin
		issue = '0;
		issue.valid = run;
		issue.dest = instr.r_form.r1;
		issue.alu_op = cpu_pkg::alu_add;
		issue.a = operand_a;
		issue.b = operand_b;
		redirect = 1'b0;
		jump_offset = imm_se;
		halt_dec = 1'b0;
		case (instr.r_form.opcode)
			cpu_pkg::op_alu: begin
				issue.reg_wr = 1'b1;
				issue.alu_op = cpu_pkg::alu_op_e'(instr.r_form.func[2:0]);
			end
			cpu_pkg::op_addi: begin
				issue.reg_wr = 1'b1;
				issue.b = imm_se;
			end
			// Load immediate as 0 + imm
			cpu_pkg::op_ldi: begin
				issue.reg_wr = 1'b1;
				issue.a = '0;
				issue.b = imm_se;
			end
			// Branch compares the forwarded r1 value
			cpu_pkg::op_beqz: begin
				redirect = (operand_a == '0);
			end
			cpu_pkg::op_jmp: begin
				redirect = 1'b1;
				jump_offset = off_se;
			end
			cpu_pkg::op_halt: begin
				halt_dec = run;
			end
			default: begin
			end
		endcase
		// R0 is hardwired, drop its writes here
		if (instr.r_form.r1 == '0) begin
			issue.reg_wr = 1'b0;
		end
		// Nothing issues or redirects outside run
		if (!run) begin
			issue.reg_wr = 1'b0;
			redirect = 1'b0;
		end
	end

	// Keep pc on the halt word from the decode cycle on
	assign hold = halt_dec || !run;
	assign halted = (state == st_halted);

	// Two drain cycles let the in-flight writes retire
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_run;
			drain_cnt <= 1'b0;
		end else begin
			case (state)
				st_run: begin
					drain_cnt <= 1'b0;
					if (halt_dec) begin
						state <= st_drain;
					end
				end
				st_drain: begin
					drain_cnt <= 1'b1;
					if (drain_cnt) begin
						state <= st_halted;
					end
				end
				default: begin
					state <= st_halted;
				end
			endcase
		end
	end

	a_no_redirect_on_hold: assert property (
		@(posedge clk) disable iff (!rst_n) hold |-> !redirect
	) else $error("redirect while fetch is held");

endmodule

// File: source/cpu_pkg.sv
package cpu_pkg;

	// Datapath, fetch address and register file sizes
	localparam int data_w = 16;
	localparam int pc_w = 16;
	localparam int reg_count = 16;
	localparam int reg_aw = 4;

	// Major opcode in the top nibble
	// Codes not listed here decode as a no-op
	typedef enum logic [3:0] {
		op_alu  = 4'd0,
		op_addi = 4'd1,
		op_ldi  = 4'd2,
		op_beqz = 4'd3,
		op_jmp  = 4'd4,
		op_halt = 4'd15
	} opcode_e;

	// ALU function, taken from func[2:0] for register-register ops
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_shl = 3'd5,
		alu_shr = 3'd6,
		alu_slt = 3'd7
	} alu_op_e;

	// Register-register layout, func[3] is spare
	typedef struct packed {
		opcode_e             opcode;
		logic [reg_aw-1:0]   r1;
		logic [reg_aw-1:0]   r2;
		logic [3:0]          func;
	} r_form_t;

	// Immediate layout for addi, ldi and beqz
	typedef struct packed {
		opcode_e             opcode;
		logic [reg_aw-1:0]   r1;
		logic [7:0]          imm8;
	} i_form_t;

	// Relative jump layout
	typedef struct packed {
		opcode_e             opcode;
		logic [11:0]         off12;
	} j_form_t;

	// One fetched word, three views of the same bits
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
		j_form_t j_form;
	} instr_u;

	// Operand source chosen by the forwarding mux
	typedef enum logic [1:0] {
		from_reg,
		from_exec,
		from_wb
	} fwd_sel_e;

	// Decode to execute payload, 41 bits
	typedef struct packed {
		logic                valid;
		logic                reg_wr;
		logic [reg_aw-1:0]   dest;
		alu_op_e             alu_op;
		logic [data_w-1:0]   a;
		logic [data_w-1:0]   b;
	} exec_t;

	// Retired register write, 21 bits
	typedef struct packed {
		logic                we;
		logic [reg_aw-1:0]   addr;
		logic [data_w-1:0]   data;
	} wb_t;

endpackage

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                      clk,
	input  logic                      rst_n,
	output logic [cpu_pkg::pc_w-1:0]  pc,
	input  cpu_pkg::instr_u           instr,
	output cpu_pkg::wb_t              wb,
	output logic                      halted
);

	// Fetch control
	logic hold;
	logic redirect;
	logic [cpu_pkg::pc_w-1:0] jump_offset;

	// Decode operands
	logic [cpu_pkg::reg_aw-1:0] r1;
	logic [cpu_pkg::reg_aw-1:0] r2;
	logic [cpu_pkg::data_w-1:0] rd1;
	logic [cpu_pkg::data_w-1:0] rd2;
	logic [cpu_pkg::data_w-1:0] operand_a;
	logic [cpu_pkg::data_w-1:0] operand_b;

	// Execute stage feedback
	cpu_pkg::exec_t issue;
	logic exec_wr;
	logic [cpu_pkg::reg_aw-1:0] exec_dest;
	logic [cpu_pkg::data_w-1:0] exec_result;

	program_counter u_pc (
		.clk         (clk),
		.rst_n       (rst_n),
		.hold        (hold),
		.redirect    (redirect),
		.jump_offset (jump_offset),
		.pc          (pc)
	);

	control_main u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.r1          (r1),
		.r2          (r2),
		.issue       (issue),
		.redirect    (redirect),
		.jump_offset (jump_offset),
		.hold        (hold),
		.halted      (halted)
	);

	register_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.r1    (r1),
		.r2    (r2),
		.wb    (wb),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	// Bypass from execute and writeback into decode
	operand_forward u_fwd (
		.r1          (r1),
		.r2          (r2),
		.rd1         (rd1),
		.rd2         (rd2),
		.exec_wr     (exec_wr),
		.exec_dest   (exec_dest),
		.exec_result (exec_result),
		.wb          (wb),
		.operand_a   (operand_a),
		.operand_b   (operand_b)
	);

	execute_pipe u_exe (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue       (issue),
		.exec_wr     (exec_wr),
		.exec_dest   (exec_dest),
		.exec_result (exec_result),
		.wb          (wb)
	);

endmodule

// File: source/execute_pipe.sv
`timescale 1ns/1ps

module execute_pipe (
	input  logic                        clk,
	input  logic                        rst_n,
	input  cpu_pkg::exec_t              issue,
	output logic                        exec_wr,
	output logic [cpu_pkg::reg_aw-1:0]  exec_dest,
	output logic [cpu_pkg::data_w-1:0]  exec_result,
	output cpu_pkg::wb_t                wb
);

	// Execute stage register
	cpu_pkg::exec_t ex_q;

	// Decode to execute boundary
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_q <= '0;
		end else begin
			ex_q <= issue;
		end
	end

	alu u_alu (
		.alu_op (ex_q.alu_op),
		.a      (ex_q.a),
		.b      (ex_q.b),
		.result (exec_result)
	);

	// Live write in execute as seen by the forwarding mux
	assign exec_wr = ex_q.valid && ex_q.reg_wr;
	assign exec_dest = ex_q.dest;

	// Execute to writeback boundary
	// wb is visible two cycles after decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else begin
			wb.we <= exec_wr;
			wb.addr <= ex_q.dest;
			wb.data <= exec_result;
		end
	end

	// R0 writes are dropped back in decode
	a_no_r0_write: assert property (
		@(posedge clk) disable iff (!rst_n) wb.we |-> (wb.addr != '0)
	) else $error("write to R0 reached writeback");

endmodule

// File: source/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
	input  logic [cpu_pkg::reg_aw-1:0]  r1,
	input  logic [cpu_pkg::reg_aw-1:0]  r2,
	input  logic [cpu_pkg::data_w-1:0]  rd1,
	input  logic [cpu_pkg::data_w-1:0]  rd2,
	input  logic                        exec_wr,
	input  logic [cpu_pkg::reg_aw-1:0]  exec_dest,
	input  logic [cpu_pkg::data_w-1:0]  exec_result,
	input  cpu_pkg::wb_t                wb,
	output logic [cpu_pkg::data_w-1:0]  operand_a,
	output logic [cpu_pkg::data_w-1:0]  operand_b
);

	cpu_pkg::fwd_sel_e sel_a;
	cpu_pkg::fwd_sel_e sel_b;

	// Youngest producer first
	// Writes to R0 never reach here, so R0 stays zero
	function automatic cpu_pkg::fwd_sel_e pick_src(
		input logic [cpu_pkg::reg_aw-1:0] src,
		input logic                       ex_wr,
		input logic [cpu_pkg::reg_aw-1:0] ex_dest,
		input cpu_pkg::wb_t               wb_in
	);
		if (ex_wr && ex_dest == src) begin
			return cpu_pkg::from_exec;
		end else if (wb_in.we && wb_in.addr == src) begin
			return cpu_pkg::from_wb;
		end
		return cpu_pkg::from_reg;
	endfunction

	always_comb begin
		sel_a = pick_src(r1, exec_wr, exec_dest, wb);
		sel_b = pick_src(r2, exec_wr, exec_dest, wb);
	end

	// Operand muxes, also the branch compare input
	always_comb begin
		case (sel_a)
			cpu_pkg::from_exec: operand_a = exec_result;
			cpu_pkg::from_wb:   operand_a = wb.data;
			default:            operand_a = rd1;
		endcase
		case (sel_b)
			cpu_pkg::from_exec: operand_b = exec_result;
			cpu_pkg::from_wb:   operand_b = wb.data;
			default:            operand_b = rd2;
		endcase
	end

endmodule

// File: source/program_counter.sv
`timescale 1ns/1ps

module program_counter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      hold,
	input  logic                      redirect,
	input  logic [cpu_pkg::pc_w-1:0]  jump_offset,
	output logic [cpu_pkg::pc_w-1:0]  pc
);

	// Next fetch address
	logic [cpu_pkg::pc_w-1:0] pc_next;

	// Hold wins, then branch or jump, else sequential fetch
	// Offsets are relative to the instruction being decoded
	always_comb begin
		if (hold) begin
			pc_next = pc;
		end else if (redirect) begin
			pc_next = pc + jump_offset;
		end else begin
			pc_next = pc + 1'b1;
		end
	end

	// Fetch starts at word 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// Frozen fetch while draining or halted
	a_hold_freezes_pc: assert property (
		@(posedge clk) disable iff (!rst_n) hold |=> $stable(pc)
	) else $error("pc moved after hold");

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [cpu_pkg::reg_aw-1:0]  r1,
	input  logic [cpu_pkg::reg_aw-1:0]  r2,
	input  cpu_pkg::wb_t                wb,
	output logic [cpu_pkg::data_w-1:0]  rd1,
	output logic [cpu_pkg::data_w-1:0]  rd2
);

	// General registers, index 0 never read back
	logic [cpu_pkg::data_w-1:0] regs [cpu_pkg::reg_count];

	// Write lands at the end of the writeback cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Asynchronous reads, R0 forced to zero
	always_comb begin
		rd1 = regs[r1];
		rd2 = regs[r2];
		if (r1 == '0) begin
			rd1 = '0;
		end
		if (r2 == '0) begin
			rd2 = '0;
		end
	end

endmodule
